// File: marble_lb.f
rtl/lb_pkg.sv
rtl/board_pkg.sv
rtl/local_bus_if.sv
rtl/spi_lb_bridge.sv
rtl/lb_decode.sv
rtl/ctrl_regs.sv
rtl/status_regs.sv
rtl/led_pwm.sv
rtl/marble_lb_top.sv
tb/tb_clkgen.sv
tb/marble_lb_sva.sv
tb/tb_marble_lb.sv

// File: rtl/board_pkg.sv
/* Board constants: feature word, build id, PWM level and Pmod types,
   synchronizer depth */
`default_nettype none

package board_pkg;

	// Bit 0 SPI bus, bit 1 Pmod1 out, bit 2 Pmod2 in, bit 3 LED PWM
	localparam logic [31:0] FEATURE_WORD = 32'h0000_000f;
	// Board id in the upper half, build number below
	localparam logic [31:0] BUILD_ID = 32'h4d41_0001;

	// PWM resolution
	localparam int PWM_BITS = 8;
	typedef logic [PWM_BITS-1:0] pwm_level_t;

	// One Pmod connector
	typedef logic [7:0] pmod_t;

	// Flops per asynchronous input
	localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire

// File: rtl/ctrl_regs.sv
/* Writable control registers: scratch, Pmod1 output
   and LED brightness levels */
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs import lb_pkg::*, board_pkg::*; (
	input  wire           lb_clk,
	input  wire           rst,
	input  wire           wr_en,
	input  wire reg_sel_t wr_sel,
	input  wire lb_data_t wdata,
	output lb_data_t      scratch,
	output pmod_t         pmod1,
	output pwm_level_t    led_level0,
	output pwm_level_t    led_level1
);

	// Update lands the cycle after the write strobe
	always_ff @(posedge lb_clk) begin
		if (rst) begin
			// LEDs and Pmod1 dark after reset
			scratch <= '0;
			pmod1 <= '0;
			led_level0 <= '0;
			led_level1 <= '0;
		end else if (wr_en) begin
			case (wr_sel)
			SEL_SCRATCH: begin
				scratch <= wdata;
			end
			SEL_PMOD1: begin
				// Low byte drives the pins
				pmod1 <= wdata[7:0];
			end
			SEL_LED_LEVEL: begin
				// LD16 in low byte, LD17 next
				led_level0 <= wdata[7:0];
				led_level1 <= wdata[15:8];
			end
			default: begin
				// Status addresses ignore writes
			end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/lb_decode.sv
/* Local-bus address decode, control write enables
   and registered read mux */
`timescale 1ns/1ps
`default_nettype none

module lb_decode import lb_pkg::*, board_pkg::*; (
	input  wire             lb_clk,
	input  wire             rst,
	local_bus_if.slave      bus,
	output logic            wr_en,
	output reg_sel_t        wr_sel,
	output lb_data_t        wdata,
	input  wire lb_data_t   scratch,
	input  wire pmod_t      pmod1,
	input  wire pwm_level_t led_level0,
	input  wire pwm_level_t led_level1,
	input  wire pmod_t      pmod2,
	input  wire lb_data_t   pmod2_changes
);

	reg_sel_t sel;
	logic ctrl_hit;
	lb_data_t rd_mux;

	// Full 24-bit compare, no aliasing
	always_comb begin
		case (bus.lb_addr)
		ADDR_FEATURES:      sel = SEL_FEATURES;
		ADDR_BUILD_ID:      sel = SEL_BUILD_ID;
		ADDR_PMOD2:         sel = SEL_PMOD2;
		ADDR_PMOD2_CHANGES: sel = SEL_PMOD2_CHANGES;
		ADDR_SCRATCH:       sel = SEL_SCRATCH;
		ADDR_PMOD1:         sel = SEL_PMOD1;
		ADDR_LED_LEVEL:     sel = SEL_LED_LEVEL;
		default:            sel = SEL_NONE;
		endcase
	end

	// Writes reach the control block only
	assign ctrl_hit = sel inside {SEL_SCRATCH, SEL_PMOD1, SEL_LED_LEVEL};
	assign wr_en = bus.lb_strobe & bus.lb_write & ctrl_hit;
	assign wr_sel = sel;
	assign wdata = bus.lb_data_out;

	always_comb begin
		case (sel)
		SEL_FEATURES:      rd_mux = FEATURE_WORD;
		SEL_BUILD_ID:      rd_mux = BUILD_ID;
		SEL_PMOD2:         rd_mux = lb_data_t'(pmod2);
		SEL_PMOD2_CHANGES: rd_mux = pmod2_changes;
		SEL_SCRATCH:       rd_mux = scratch;
		SEL_PMOD1:         rd_mux = lb_data_t'(pmod1);
		// Level1 above level0, zeros above bit 15
		SEL_LED_LEVEL:     rd_mux = lb_data_t'({led_level1, led_level0});
		default:           rd_mux = LB_UNMAPPED_DATA;
		endcase
	end

	// Read data one cycle after strobe
	always_ff @(posedge lb_clk) begin
		if (rst) begin
			bus.lb_rd_valid <= 1'b0;
		end else begin
			bus.lb_rd_valid <= bus.lb_strobe & bus.lb_rd;
		end
	end

	always_ff @(posedge lb_clk) begin
		if (bus.lb_strobe && bus.lb_rd) begin
			bus.lb_din <= rd_mux;
		end
	end

endmodule

`default_nettype wire

// File: rtl/lb_pkg.sv
/* Local-bus types, SPI frame size, register address map
   and the register select enum */
`default_nettype none

package lb_pkg;

	// Bus widths
	typedef logic [23:0] lb_addr_t;
	typedef logic [31:0] lb_data_t;
	// SPI command byte, bit 7 set for read
	typedef logic [7:0] lb_cmd_t;

	// Status block, read only
	localparam lb_addr_t ADDR_FEATURES      = 24'h000000;
	localparam lb_addr_t ADDR_BUILD_ID      = 24'h000001;
	localparam lb_addr_t ADDR_PMOD2         = 24'h000002;
	localparam lb_addr_t ADDR_PMOD2_CHANGES = 24'h000003;
	// Control block, read/write
	localparam lb_addr_t ADDR_SCRATCH       = 24'h000010;
	localparam lb_addr_t ADDR_PMOD1         = 24'h000011;
	localparam lb_addr_t ADDR_LED_LEVEL     = 24'h000012;

	// Returned for any address outside the map
	localparam lb_data_t LB_UNMAPPED_DATA = 32'hfaceface;

	// Command, address, data
	localparam int SPI_FRAME_BITS = 64;

	// Decoded register
	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_FEATURES,
		SEL_BUILD_ID,
		SEL_PMOD2,
		SEL_PMOD2_CHANGES,
		SEL_SCRATCH,
		SEL_PMOD1,
		SEL_LED_LEVEL
	} reg_sel_t;

endpackage

`default_nettype wire

// File: rtl/led_pwm.sv
/* Two-channel 8-bit PWM for LD16 and LD17 */
`timescale 1ns/1ps
`default_nettype none

module led_pwm import board_pkg::*; (
	input  wire             lb_clk,
	input  wire             rst,
	input  wire pwm_level_t level0,
	input  wire pwm_level_t level1,
	output logic            ld16,
	output logic            ld17
);

	// Shared by both channels, period 256
	pwm_level_t pwm_cnt;

	always_ff @(posedge lb_clk) begin
		if (rst) begin
			pwm_cnt <= '0;
			ld16 <= 1'b0;
			ld17 <= 1'b0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
			// High for level counts per period
			ld16 <= pwm_cnt < level0;
			ld17 <= pwm_cnt < level1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/local_bus_if.sv
/* Local-bus interface, master and slave modports */
`timescale 1ns/1ps
`default_nettype none

interface local_bus_if import lb_pkg::*; ();

	// One-cycle transaction qualifier
	logic     lb_strobe;
	logic     lb_rd;
	logic     lb_write;
	lb_addr_t lb_addr;
	// Write data from the master
	lb_data_t lb_data_out;
	// Read data, valid with lb_rd_valid
	lb_data_t lb_din;
	logic     lb_rd_valid;

	// SPI bridge side
	modport master (
		output lb_strobe, lb_rd, lb_write, lb_addr, lb_data_out,
		input  lb_din, lb_rd_valid
	);

	// Decoder side, always accepts
	modport slave (
		input  lb_strobe, lb_rd, lb_write, lb_addr, lb_data_out,
		output lb_din, lb_rd_valid
	);

endinterface

`default_nettype wire

// File: rtl/marble_lb_top.sv
/* Top level: SPI bridge, local-bus decode, control and status
   registers, LED PWM */
`timescale 1ns/1ps
`default_nettype none

module marble_lb_top import lb_pkg::*, board_pkg::*; (
	input  wire       lb_clk,
	input  wire       rst,
	// SPI from the microcontroller
	input  wire       SCLK,
	input  wire       CSB,
	input  wire       MOSI,
	output wire       MISO,
	// Directly attached LEDs
	output wire       LD16,
	output wire       LD17,
	// Pmod connectors
	output wire [7:0] Pmod1,
	input  wire [7:0] Pmod2
);

	// Bridge to decoder
	local_bus_if lb ();

	// Decoder to control block
	logic       wr_en;
	reg_sel_t   wr_sel;
	lb_data_t   wdata;
	// Register values back to the read mux
	lb_data_t   scratch;
	pwm_level_t led_level0;
	pwm_level_t led_level1;
	pmod_t      pmod2;
	lb_data_t   pmod2_changes;

	spi_lb_bridge u_bridge (
		.lb_clk (lb_clk),
		.rst    (rst),
		.sclk   (SCLK),
		.csb    (CSB),
		.mosi   (MOSI),
		.miso   (MISO),
		.bus    (lb.master)
	);

	lb_decode u_decode (
		.lb_clk        (lb_clk),
		.rst           (rst),
		.bus           (lb.slave),
		.wr_en         (wr_en),
		.wr_sel        (wr_sel),
		.wdata         (wdata),
		.scratch       (scratch),
		.pmod1         (Pmod1),
		.led_level0    (led_level0),
		.led_level1    (led_level1),
		.pmod2         (pmod2),
		.pmod2_changes (pmod2_changes)
	);

	ctrl_regs u_ctrl (
		.lb_clk     (lb_clk),
		.rst        (rst),
		.wr_en      (wr_en),
		.wr_sel     (wr_sel),
		.wdata      (wdata),
		.scratch    (scratch),
		.pmod1      (Pmod1),
		.led_level0 (led_level0),
		.led_level1 (led_level1)
	);

	status_regs u_status (
		.lb_clk        (lb_clk),
		.rst           (rst),
		.pmod2_in      (Pmod2),
		.pmod2         (pmod2),
		.pmod2_changes (pmod2_changes)
	);

	led_pwm u_pwm (
		.lb_clk (lb_clk),
		.rst    (rst),
		.level0 (led_level0),
		.level1 (led_level1),
		.ld16   (LD16),
		.ld17   (LD17)
	);

endmodule

`default_nettype wire

// File: rtl/spi_lb_bridge.sv
/* SPI slave to local-bus master bridge, 64-bit frames
   of command, address and data */
`timescale 1ns/1ps
`default_nettype none

module spi_lb_bridge import lb_pkg::*, board_pkg::*; (
	input  wire         lb_clk,
	input  wire         rst,
	input  wire         sclk,
	input  wire         csb,
	input  wire         mosi,
	output wire         miso,
	local_bus_if.master bus
);

	typedef enum logic [1:0] {IDLE, SHIFT, RD_WAIT, DONE} state_t;

	// Read strobe goes out after command and address
	localparam int HALF_BITS = SPI_FRAME_BITS / 2;

	logic [SYNC_STAGES-1:0] sclk_sync;
	logic [SYNC_STAGES-1:0] csb_sync;
	logic [SYNC_STAGES-1:0] mosi_sync;
	logic sclk_prev;
	logic sclk_s;
	logic csb_s;
	logic mosi_s;
	logic sclk_rise;
	logic sclk_fall;
	state_t state;
	logic [$clog2(SPI_FRAME_BITS)-1:0] bit_cnt;
	logic [SPI_FRAME_BITS-1:0] shift_reg;
	lb_cmd_t cmd;
	logic rd_active;
	logic miso_q;

	// Input synchronizers, CSB idles high
	always_ff @(posedge lb_clk) begin
		if (rst) begin
			sclk_sync <= '0;
			csb_sync <= '1;
			sclk_prev <= 1'b0;
		end else begin
			sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], sclk};
			csb_sync <= {csb_sync[SYNC_STAGES-2:0], csb};
			sclk_prev <= sclk_s;
		end
	end

	// Data line needs no reset
	always_ff @(posedge lb_clk) begin
		mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi};
	end

	assign sclk_s = sclk_sync[SYNC_STAGES-1];
	assign csb_s = csb_sync[SYNC_STAGES-1];
	assign mosi_s = mosi_sync[SYNC_STAGES-1];
	assign sclk_rise = sclk_s & ~sclk_prev;
	assign sclk_fall = ~sclk_s & sclk_prev;

	// Command byte position just before the 32nd bit shifts in
	assign cmd = shift_reg[HALF_BITS-2 -: $bits(lb_cmd_t)];

	// Frame FSM and bus strobes
	always_ff @(posedge lb_clk) begin
		if (rst) begin
			state <= IDLE;
			bit_cnt <= '0;
			rd_active <= 1'b0;
			miso_q <= 1'b0;
			bus.lb_strobe <= 1'b0;
			bus.lb_rd <= 1'b0;
			bus.lb_write <= 1'b0;
		end else begin
			// Strobes last one cycle
			bus.lb_strobe <= 1'b0;
			bus.lb_rd <= 1'b0;
			bus.lb_write <= 1'b0;
			// Mode 0, output moves on falling edge
			if (sclk_fall) begin
				miso_q <= rd_active & shift_reg[SPI_FRAME_BITS-1];
			end
			case (state)
			IDLE: begin
				bit_cnt <= '0;
				rd_active <= 1'b0;
				miso_q <= 1'b0;
				if (!csb_s) begin
					state <= SHIFT;
				end
			end
			SHIFT: begin
				// Early CSB release drops the frame
				if (csb_s) begin
					state <= IDLE;
				end else if (sclk_rise) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == HALF_BITS - 1 && cmd[7]) begin
						state <= RD_WAIT;
						bus.lb_strobe <= 1'b1;
						bus.lb_rd <= 1'b1;
					end else if (bit_cnt == SPI_FRAME_BITS - 1) begin
						state <= DONE;
						rd_active <= 1'b0;
						// Read frames only shift out data here
						if (!rd_active) begin
							bus.lb_strobe <= 1'b1;
							bus.lb_write <= 1'b1;
						end
					end
				end
			end
			RD_WAIT: begin
				if (csb_s) begin
					state <= IDLE;
				end else if (bus.lb_rd_valid) begin
					rd_active <= 1'b1;
					state <= SHIFT;
				end
			end
			DONE: begin
				// Wait for end of frame
				if (csb_s) begin
					state <= IDLE;
				end
			end
			default: state <= IDLE;
			endcase
		end
	end

	// Shift register, address and write data
	always_ff @(posedge lb_clk) begin
		if (state == RD_WAIT && bus.lb_rd_valid) begin
			// Returned word goes out MSB first
			shift_reg[SPI_FRAME_BITS-1 -: $bits(lb_data_t)] <= bus.lb_din;
		end else if (state != IDLE && sclk_rise) begin
			shift_reg <= {shift_reg[SPI_FRAME_BITS-2:0], mosi_s};
		end
		if (state == SHIFT && sclk_rise) begin
			// Address in bits 22:0 plus the incoming bit
			if (bit_cnt == HALF_BITS - 1) begin
				bus.lb_addr <= {shift_reg[22:0], mosi_s};
			end else if (bit_cnt == SPI_FRAME_BITS - 1) begin
				bus.lb_addr <= shift_reg[54:31];
				bus.lb_data_out <= {shift_reg[30:0], mosi_s};
			end
		end
	end

	// Pin goes quiet as soon as CSB rises
	assign miso = miso_q & ~csb;

endmodule

`default_nettype wire

// File: rtl/status_regs.sv
/* Pmod2 input synchronizer and 32-bit change counter */
`timescale 1ns/1ps
`default_nettype none

module status_regs import lb_pkg::*, board_pkg::*; (
	input  wire        lb_clk,
	input  wire        rst,
	input  wire pmod_t pmod2_in,
	output pmod_t      pmod2,
	output lb_data_t   pmod2_changes
);

	pmod_t sync_q [SYNC_STAGES];
	pmod_t pmod2_prev;

	// Pins are asynchronous to lb_clk
	always_ff @(posedge lb_clk) begin
		sync_q[0] <= pmod2_in;
		for (int i = 1; i < SYNC_STAGES; i++) begin
			sync_q[i] <= sync_q[i-1];
		end
	end

	// Last stage is the sample
	assign pmod2 = sync_q[SYNC_STAGES-1];

	// Previous value keeps tracking during reset
	always_ff @(posedge lb_clk) begin
		pmod2_prev <= pmod2;
	end

	// So reset release counts no change
	always_ff @(posedge lb_clk) begin
		if (rst) begin
			pmod2_changes <= '0;
		end else if (pmod2 != pmod2_prev) begin
			// Wraps at 2^32
			pmod2_changes <= pmod2_changes + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: tb/marble_lb_sva.sv
/* Local-bus and SPI pin assertions, bound into the SPI bridge */
`timescale 1ns/1ps
`default_nettype none

module marble_lb_sva (
	input logic lb_clk,
	input logic rst,
	input logic strobe,
	input logic rd,
	input logic write,
	input logic rd_valid,
	input logic csb,
	input logic miso,
	input logic bridge_idle
);

	// Count of failed assertions
	int failures = 0;

	// Read data comes back exactly one cycle after a read strobe
	a_rd_valid_after_strobe: assert property (
		@(posedge lb_clk) disable iff (rst) (strobe && rd) |=> rd_valid
	) else begin
		failures++;
		$error("lb_rd_valid missing one cycle after a read strobe");
	end

	a_rd_valid_only_after_strobe: assert property (
		@(posedge lb_clk) disable iff (rst) rd_valid |-> $past(strobe && rd)
	) else begin
		failures++;
		$error("lb_rd_valid high without a read strobe in the previous cycle");
	end

	// Read and write qualifiers are exclusive
	a_rd_write_exclusive: assert property (
		@(posedge lb_clk) disable iff (rst) strobe |-> !(rd && write)
	) else begin
		failures++;
		$error("lb_rd and lb_write both set with lb_strobe");
	end

	// Deselected slave keeps MISO low
	a_miso_quiet: assert property (
		@(posedge lb_clk) disable iff (rst) csb |-> !miso
	) else begin
		failures++;
		$error("MISO high while CSB is high");
	end

	a_no_idle_strobe: assert property (
		@(posedge lb_clk) disable iff (rst) strobe |-> !bridge_idle
	) else begin
		failures++;
		$error("lb_strobe issued while the bridge FSM is idle");
	end

endmodule

// Bridge sees both the bus and the SPI pins
bind spi_lb_bridge marble_lb_sva u_sva (
	.lb_clk      (lb_clk),
	.rst         (rst),
	.strobe      (bus.lb_strobe),
	.rd          (bus.lb_rd),
	.write       (bus.lb_write),
	.rd_valid    (bus.lb_rd_valid),
	.csb         (csb),
	.miso        (miso),
	.bridge_idle (state == IDLE)
);

`default_nettype wire

// File: tb/tb_clkgen.sv
/* Testbench clock and reset source */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic lb_clk,
	output logic rst
);

	// 100 MHz local-bus clock
	initial begin
		lb_clk = 1'b0;
		forever #5 lb_clk = ~lb_clk;
	end

	// Reset held for 8 rising edges, released just after an edge
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge lb_clk);
		#1 rst = 1'b0;
	end

endmodule

`default_nettype wire

// File: tb/tb_marble_lb.sv
/* Top-level testbench: SPI frame driver, register model, compare tasks,
   random stimulus and cycle timeout */
`timescale 1ns/1ps
`default_nettype none

module tb_marble_lb import lb_pkg::*, board_pkg::*; ();

	// SCLK half period in lb_clk cycles
	localparam int SCLK_HALF = 8;
	// Frame plus CSB setup, hold and gap
	localparam int FRAME_CYCLES = (SPI_FRAME_BITS + 4) * 2 * SCLK_HALF;
	// 63 frames in the tests, three spare
	localparam int NUM_FRAMES = 66;
	// Pmod2 holds, PWM window and reset
	localparam int MAX_CYCLES = NUM_FRAMES * FRAME_CYCLES + 4096;

	localparam lb_cmd_t CMD_WRITE = 8'h00;
	localparam lb_cmd_t CMD_READ = 8'h80;

	logic lb_clk;
	logic rst;
	logic sclk;
	logic csb;
	logic mosi;
	wire miso;
	wire ld16;
	wire ld17;
	wire [7:0] pmod1_pins;
	logic [7:0] pmod2_pins;

	logic [31:0] rng_state;
	int checks;
	int errors;
	int tests;
	int mark_checks;
	int mark_errors;
	int cycle_count;

	// Shadow registers
	lb_data_t m_scratch;
	pmod_t m_pmod1;
	pwm_level_t m_level0;
	pwm_level_t m_level1;
	pmod_t m_pmod2;
	lb_data_t m_changes;

	tb_clkgen u_clkgen (
		.lb_clk (lb_clk),
		.rst    (rst)
	);

	marble_lb_top DUT (
		.lb_clk (lb_clk),
		.rst    (rst),
		.SCLK   (sclk),
		.CSB    (csb),
		.MOSI   (mosi),
		.MISO   (miso),
		.LD16   (ld16),
		.LD17   (ld17),
		.Pmod1  (pmod1_pins),
		.Pmod2  (pmod2_pins)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Register map as seen over SPI
	function automatic lb_data_t expected_read(input lb_addr_t addr);
		case (addr)
		24'h000000: return FEATURE_WORD;
		24'h000001: return BUILD_ID;
		24'h000002: return {24'h0, m_pmod2};
		24'h000003: return m_changes;
		24'h000010: return m_scratch;
		24'h000011: return {24'h0, m_pmod1};
		24'h000012: return {16'h0, m_level1, m_level0};
		default:    return 32'hfaceface;
		endcase
	endfunction

	function automatic bit is_mapped(input lb_addr_t addr);
		return (addr <= 24'h000003) || (addr >= 24'h000010 && addr <= 24'h000012);
	endfunction

	// Status addresses ignore writes
	task automatic model_write(input lb_addr_t addr, input lb_data_t data);
		case (addr)
		24'h000010: m_scratch = data;
		24'h000011: m_pmod1 = data[7:0];
		24'h000012: begin
			m_level0 = data[7:0];
			m_level1 = data[15:8];
		end
		default: ;
		endcase
	endtask

	// Inputs move 1 ns after the rising edge
	task automatic tick(input int n);
		repeat (n) @(posedge lb_clk);
		#1;
	endtask

	task automatic check_data(input string name, input lb_data_t got, input lb_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_pmod(input string name, input pmod_t got, input pmod_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_level(input string name, input pwm_level_t got,
			input pwm_level_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// Mode 0 frame, MSB first; MISO taken on rising edges of bits 33 to 64
	task automatic spi_frame(input lb_cmd_t cmd, input lb_addr_t addr, input lb_data_t wdata,
			input int nbits, output lb_data_t rdata);
		logic [SPI_FRAME_BITS-1:0] frame;
		int i;
		frame = {cmd, addr, wdata};
		rdata = '0;
		csb = 1'b0;
		tick(SCLK_HALF);
		for (i = 0; i < nbits; i++) begin
			mosi = frame[SPI_FRAME_BITS-1-i];
			tick(SCLK_HALF);
			if (i >= SPI_FRAME_BITS / 2) begin
				rdata = {rdata[30:0], miso};
			end
			sclk = 1'b1;
			tick(SCLK_HALF);
			sclk = 1'b0;
		end
		tick(SCLK_HALF);
		csb = 1'b1;
		mosi = 1'b0;
		// Bridge back to idle before the next frame
		tick(2 * SCLK_HALF);
	endtask

	task automatic spi_write(input lb_addr_t addr, input lb_data_t data);
		lb_data_t unused;
		spi_frame(CMD_WRITE, addr, data, SPI_FRAME_BITS, unused);
	endtask

	task automatic spi_read(input lb_addr_t addr, output lb_data_t data);
		spi_frame(CMD_READ, addr, 32'h0, SPI_FRAME_BITS, data);
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("Test %0d %s: %0d checks, %0d errors", tests, name,
			checks - mark_checks, errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	// Hard stop on a hung run
	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge lb_clk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : main
		lb_data_t rdata;
		lb_data_t wdata;
		lb_addr_t addr;
		logic [31:0] r;
		pmod_t p;
		int n16;
		int n17;
		int i;

		sclk = 1'b0;
		csb = 1'b1;
		mosi = 1'b0;
		pmod2_pins = 8'h00;
		rng_state = 32'hdcd9_cffa;
		checks = 0;
		errors = 0;
		tests = 0;
		mark_checks = 0;
		mark_errors = 0;
		m_scratch = '0;
		m_pmod1 = '0;
		m_level0 = '0;
		m_level1 = '0;
		m_pmod2 = '0;
		m_changes = '0;

		tick(1);
		while (rst) begin
			tick(1);
		end
		tick(4);

		// Constants and reset values
		spi_read(ADDR_FEATURES, rdata);
		check_data("features", rdata, expected_read(ADDR_FEATURES));
		spi_read(ADDR_BUILD_ID, rdata);
		check_data("build_id", rdata, expected_read(ADDR_BUILD_ID));
		spi_read(ADDR_SCRATCH, rdata);
		check_data("scratch", rdata, expected_read(ADDR_SCRATCH));
		spi_read(ADDR_PMOD1, rdata);
		check_data("pmod1 word", rdata, expected_read(ADDR_PMOD1));
		spi_read(ADDR_LED_LEVEL, rdata);
		check_data("led word", rdata, expected_read(ADDR_LED_LEVEL));
		check_pmod("Pmod1", pmod1_pins, m_pmod1);
		report_test("reset values");

		// Scratch write then read, twenty times
		for (i = 0; i < 20; i++) begin
			wdata = next_random();
			spi_write(ADDR_SCRATCH, wdata);
			model_write(ADDR_SCRATCH, wdata);
			spi_read(ADDR_SCRATCH, rdata);
			check_data("scratch", rdata, expected_read(ADDR_SCRATCH));
		end
		report_test("scratch write/read");

		// Upper bits random, only the low byte lands
		wdata = next_random();
		spi_write(ADDR_PMOD1, wdata);
		model_write(ADDR_PMOD1, wdata);
		check_pmod("Pmod1", pmod1_pins, m_pmod1);
		spi_read(ADDR_PMOD1, rdata);
		check_data("pmod1 word", rdata, expected_read(ADDR_PMOD1));
		report_test("Pmod1 output");

		// Unmapped read, then a frame cut after 40 bits
		do begin
			r = next_random();
			addr = r[23:0];
		end while (is_mapped(addr));
		spi_read(addr, rdata);
		check_data("unmapped", rdata, expected_read(addr));
		wdata = next_random();
		spi_frame(CMD_WRITE, ADDR_SCRATCH, wdata, 40, rdata);
		spi_read(ADDR_SCRATCH, rdata);
		check_data("scratch after short frame", rdata, expected_read(ADDR_SCRATCH));
		report_test("unmapped and short frame");

		// Pmod2 samples and change count
		for (i = 0; i < 10; i++) begin
			r = next_random();
			p = r[7:0];
			if (p != m_pmod2) begin
				m_changes++;
			end
			m_pmod2 = p;
			pmod2_pins = p;
			tick(20);
			spi_read(ADDR_PMOD2, rdata);
			check_data("pmod2 word", rdata, expected_read(ADDR_PMOD2));
		end
		spi_read(ADDR_PMOD2_CHANGES, rdata);
		check_data("pmod2_changes", rdata, expected_read(ADDR_PMOD2_CHANGES));
		report_test("Pmod2 input");

		// LED levels, duty over one full PWM period
		wdata = next_random();
		spi_write(ADDR_LED_LEVEL, wdata);
		model_write(ADDR_LED_LEVEL, wdata);
		n16 = 0;
		n17 = 0;
		for (i = 0; i < 256; i++) begin
			tick(1);
			if (ld16) begin
				n16++;
			end
			if (ld17) begin
				n17++;
			end
		end
		check_level("LD16 high cycles", pwm_level_t'(n16), m_level0);
		check_level("LD17 high cycles", pwm_level_t'(n17), m_level1);
		spi_read(ADDR_LED_LEVEL, rdata);
		check_data("led word", rdata, expected_read(ADDR_LED_LEVEL));
		report_test("LED PWM");

		// Bus and SPI pin assertions in the bridge
		if (DUT.u_bridge.u_sva.failures != 0) begin
			errors += DUT.u_bridge.u_sva.failures;
			$display("Bus checker reported %0d assertion failures",
				DUT.u_bridge.u_sva.failures);
		end

		$display("Totals: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
